// File: src/harnessPkg.sv
package harnessPkg;

	//------------------------------------------------------------
	// command opcodes
	//------------------------------------------------------------
	localparam logic [7:0] opWrite     = 8'h00;   // store payload word
	localparam logic [7:0] opBurstRead = 8'h02;   // strided read, count words

	// single byte sent back for anything else
	localparam logic [7:0] errReply = 8'hEE;

	// opcode, two address bytes, four payload bytes
	localparam int cmdBytes = 7;

	//------------------------------------------------------------
	// payload word
	//------------------------------------------------------------
	// a write uses the whole word as data, a burst read splits it
	// into a count in the upper half and a stride in the lower half
	typedef union packed {
		logic [31:0] wrView;
		struct packed {
			logic [15:0] count;    // words to return
			logic [15:0] stride;   // address step per word
		} rdView;
	} cmdPayload_u;

endpackage

// File: src/uartLink.sv
`timescale 1ns/100ps

module uartLink #(
	parameter int clkPerBit = 16
) (
	input  logic       sys_clk_p,
	input  logic       rstN,
	input  logic       uartRx,
	output logic       uartTx,
	output logic [7:0] rxByte,
	output logic       rxStrobe,
	input  logic [7:0] txByte,
	input  logic       txStart,
	output logic       txBusy
);

	localparam int cntW = $clog2(clkPerBit);

	//------------------------------------------------------------
	// receiver
	//------------------------------------------------------------
	logic [1:0]      rxSync;
	logic            rxLine;
	logic            rxActive;
	logic [cntW-1:0] rxCnt;
	logic [3:0]      rxBitIdx;   // 0 start, 1..8 data, 9 stop
	logic [7:0]      rxShift;
	logic            rxSample;

	assign rxLine   = rxSync[1];
	assign rxSample = rxActive && (rxCnt == '0);

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			rxSync <= 2'b11;   // idle line is high
		end else begin
			rxSync <= {rxSync[0], uartRx};
		end
	end

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			rxActive <= 1'b0;
			rxCnt    <= '0;
			rxBitIdx <= '0;
			rxStrobe <= 1'b0;
		end else begin
			rxStrobe <= 1'b0;
			if (!rxActive) begin
				if (!rxLine) begin
					// falling edge, wait half a bit to land mid start bit
					rxActive <= 1'b1;
					rxCnt    <= cntW'(clkPerBit / 2 - 1);
					rxBitIdx <= '0;
				end
			end else if (rxCnt != '0) begin
				rxCnt <= rxCnt - 1'b1;
			end else begin
				rxCnt    <= cntW'(clkPerBit - 1);
				rxBitIdx <= rxBitIdx + 1'b1;
				if (rxBitIdx == 4'd0 && rxLine) begin
					rxActive <= 1'b0;   // glitch, not a real start bit
				end else if (rxBitIdx == 4'd9) begin
					rxActive <= 1'b0;
					rxStrobe <= rxLine;   // bad stop bit drops the byte
				end
			end
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (rxSample && rxBitIdx >= 4'd1 && rxBitIdx <= 4'd8)
			rxShift <= {rxLine, rxShift[7:1]};   // lsb arrives first
		if (rxSample && rxBitIdx == 4'd9 && rxLine)
			rxByte <= rxShift;
	end

	//------------------------------------------------------------
	// transmitter
	//------------------------------------------------------------
	logic [8:0]      txShift;   // data bits then stop bit
	logic [cntW-1:0] txCnt;
	logic [3:0]      txBitIdx;

	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			uartTx   <= 1'b1;
			txBusy   <= 1'b0;
			txCnt    <= '0;
			txBitIdx <= '0;
		end else if (!txBusy) begin
			if (txStart) begin
				txBusy   <= 1'b1;
				uartTx   <= 1'b0;   // start bit
				txCnt    <= cntW'(clkPerBit - 1);
				txBitIdx <= '0;
			end
		end else if (txCnt != '0) begin
			txCnt <= txCnt - 1'b1;
		end else begin
			txCnt <= cntW'(clkPerBit - 1);
			if (txBitIdx == 4'd9) begin
				txBusy <= 1'b0;   // stop bit period done
			end else begin
				uartTx   <= txShift[txBitIdx];
				txBitIdx <= txBitIdx + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (txStart && !txBusy)
			txShift <= {1'b1, txByte};
	end

endmodule

// File: src/cmdDecode.sv
`timescale 1ns/100ps

module cmdDecode import harnessPkg::*; #(
	parameter int clkPerBit = 16
) (
	input  logic        sys_clk_p,
	input  logic        rstN,
	input  logic [7:0]  rxByte,
	input  logic        rxStrobe,
	output logic [7:0]  cmdOp,
	output logic [15:0] cmdAddr,
	output cmdPayload_u cmdPayload,
	output logic        cmdStrobe
);

	localparam int frameW   = cmdBytes * 8;
	localparam int cntW     = $clog2(cmdBytes + 1);
	localparam int gapLimit = 40 * clkPerBit;   // four frames of 10 bits
	localparam int gapW     = $clog2(gapLimit + 1);

	logic [frameW-1:0] frameBuf;
	logic [cntW-1:0]   byteCnt;
	logic [gapW-1:0]   idleTimer;
	logic              lastByte;

	assign lastByte = rxStrobe && (byteCnt == cntW'(cmdBytes - 1));

	//------------------------------------------------------------
	// byte count and idle timeout
	//------------------------------------------------------------
	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			byteCnt   <= '0;
			idleTimer <= '0;
			cmdStrobe <= 1'b0;
		end else begin
			cmdStrobe <= lastByte;
			if (rxStrobe) begin
				idleTimer <= '0;
				byteCnt   <= lastByte ? '0 : byteCnt + 1'b1;
			end else if (byteCnt != '0) begin
				if (idleTimer == gapW'(gapLimit)) begin
					byteCnt   <= '0;   // stale partial frame
					idleTimer <= '0;
				end else begin
					idleTimer <= idleTimer + 1'b1;
				end
			end
		end
	end

	// msb first, so older bytes move up
	always_ff @(posedge sys_clk_p) begin
		if (rxStrobe)
			frameBuf <= {frameBuf[frameW-9:0], rxByte};
	end

	// field split, valid alongside cmdStrobe
	assign cmdOp      = frameBuf[55:48];
	assign cmdAddr    = frameBuf[47:32];
	assign cmdPayload = frameBuf[31:0];

endmodule

// File: src/memExecute.sv
`timescale 1ns/100ps

module memExecute import harnessPkg::*; #(
	parameter int addrWidth = 8
) (
	input  logic        sys_clk_p,
	input  logic        rstN,
	input  logic [7:0]  cmdOp,
	input  logic [15:0] cmdAddr,
	input  cmdPayload_u cmdPayload,
	input  logic        cmdStrobe,
	input  logic        serBusy,
	output logic [31:0] wordData,
	output logic        wordStrobe,
	output logic        errStrobe
);

	localparam int depth = 1 << addrWidth;

	logic [31:0]          mem [depth];
	logic [31:0]          rdData;
	logic                 burstActive;
	logic                 rdPending;   // read issued, word out next cycle
	logic [15:0]          remaining;
	logic [addrWidth-1:0] rdAddr;
	logic [addrWidth-1:0] stride;
	logic                 cmdIdle;
	logic                 issue;
	logic                 takeCmd;

	assign cmdIdle = !burstActive && !rdPending;
	assign takeCmd = cmdStrobe && cmdIdle;   // commands during a burst are dropped
	assign issue   = burstActive && !rdPending && !serBusy;

	//------------------------------------------------------------
	// memory array
	//------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (takeCmd && cmdOp == opWrite)
			mem[cmdAddr[addrWidth-1:0]] <= cmdPayload.wrView;
		if (issue)
			rdData <= mem[rdAddr];
	end

	//------------------------------------------------------------
	// burst sequencer
	//------------------------------------------------------------
	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			burstActive <= 1'b0;
			rdPending   <= 1'b0;
			remaining   <= '0;
			rdAddr      <= '0;
			stride      <= '0;
			errStrobe   <= 1'b0;
		end else begin
			errStrobe <= 1'b0;
			rdPending <= issue;
			if (takeCmd) begin
				if (cmdOp == opBurstRead) begin
					burstActive <= (cmdPayload.rdView.count != 16'd0);   // zero count, no reply
					remaining   <= cmdPayload.rdView.count;
					rdAddr      <= cmdAddr[addrWidth-1:0];
					stride      <= cmdPayload.rdView.stride[addrWidth-1:0];
				end else if (cmdOp != opWrite) begin
					errStrobe <= 1'b1;
				end
			end else if (issue) begin
				rdAddr    <= rdAddr + stride;   // wraps at the depth
				remaining <= remaining - 1'b1;
				if (remaining == 16'd1)
					burstActive <= 1'b0;
			end
		end
	end

	assign wordStrobe = rdPending;
	assign wordData   = rdData;

endmodule

// File: src/resultSerialize.sv
`timescale 1ns/100ps

module resultSerialize import harnessPkg::*; (
	input  logic        sys_clk_p,
	input  logic        rstN,
	input  logic [31:0] wordData,
	input  logic        wordStrobe,
	input  logic        errStrobe,
	input  logic        txBusy,
	output logic [7:0]  txByte,
	output logic        txStart,
	output logic        serBusy
);

	logic [31:0] outWord;     // next byte sits in the top lane
	logic [2:0]  bytesLeft;

	// hand a byte over as soon as the line is free
	assign txStart = (bytesLeft != 3'd0) && !txBusy;
	assign txByte  = outWord[31:24];

	//------------------------------------------------------------
	// byte count and busy
	//------------------------------------------------------------
	always_ff @(posedge sys_clk_p or negedge rstN) begin
		if (!rstN) begin
			bytesLeft <= '0;
			serBusy   <= 1'b0;
		end else if (wordStrobe) begin
			bytesLeft <= 3'd4;
			serBusy   <= 1'b1;
		end else if (errStrobe) begin
			bytesLeft <= 3'd1;   // just the error code
			serBusy   <= 1'b1;
		end else if (txStart) begin
			bytesLeft <= bytesLeft - 1'b1;
			if (bytesLeft == 3'd1)
				serBusy <= 1'b0;   // last byte has started
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (wordStrobe)
			outWord <= wordData;
		else if (errStrobe)
			outWord <= {errReply, 24'h000000};
		else if (txStart)
			outWord <= {outWord[23:0], 8'h00};
	end

endmodule

// File: src/uartMemHarness.sv
`timescale 1ns/100ps

module uartMemHarness import harnessPkg::*; #(
	parameter int clkPerBit = 16,
	parameter int addrWidth = 8
) (
	input  logic sys_clk_p,
	input  logic rstN,
	input  logic uartRx,
	output logic uartTx
);

	//------------------------------------------------------------
	// internal links
	//------------------------------------------------------------
	logic [7:0]  rxByte;
	logic        rxStrobe;
	logic [7:0]  cmdOp;
	logic [15:0] cmdAddr;
	cmdPayload_u cmdPayload;
	logic        cmdStrobe;
	logic [31:0] wordData;
	logic        wordStrobe;
	logic        errStrobe;
	logic        serBusy;
	logic [7:0]  txByte;
	logic        txStart;
	logic        txBusy;

	uartLink #(
		.clkPerBit(clkPerBit)
	) u_uartLink (
		.sys_clk_p(sys_clk_p),
		.rstN     (rstN),
		.uartRx   (uartRx),
		.uartTx   (uartTx),
		.rxByte   (rxByte),
		.rxStrobe (rxStrobe),
		.txByte   (txByte),
		.txStart  (txStart),
		.txBusy   (txBusy)
	);

	cmdDecode #(
		.clkPerBit(clkPerBit)   // idle timeout in bit periods
	) u_cmdDecode (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.rxByte    (rxByte),
		.rxStrobe  (rxStrobe),
		.cmdOp     (cmdOp),
		.cmdAddr   (cmdAddr),
		.cmdPayload(cmdPayload),
		.cmdStrobe (cmdStrobe)
	);

	memExecute #(
		.addrWidth(addrWidth)
	) u_memExecute (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.cmdOp     (cmdOp),
		.cmdAddr   (cmdAddr),
		.cmdPayload(cmdPayload),
		.cmdStrobe (cmdStrobe),
		.serBusy   (serBusy),
		.wordData  (wordData),
		.wordStrobe(wordStrobe),
		.errStrobe (errStrobe)
	);

	resultSerialize u_resultSerialize (
		.sys_clk_p (sys_clk_p),
		.rstN      (rstN),
		.wordData  (wordData),
		.wordStrobe(wordStrobe),
		.errStrobe (errStrobe),
		.txBusy    (txBusy),
		.txByte    (txByte),
		.txStart   (txStart),
		.serBusy   (serBusy)
	);

endmodule

// File: dv/uartMemHarness_props.sv
`timescale 1ns/100ps

module uartMemHarness_props (
	input logic sys_clk_p,
	input logic rstN,
	input logic cmdStrobe,
	input logic wordStrobe,
	input logic serBusy,
	input logic txBusy,
	input logic uartTx
);

	cmdOneCycle: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		cmdStrobe |=> !cmdStrobe)
		else $error("cmdStrobe high for more than one cycle");

	wordOneCycle: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		wordStrobe |=> !wordStrobe)
		else $error("wordStrobe high for more than one cycle");

	// serializer must be free before a word is handed over
	wordWhenFree: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		wordStrobe |-> !serBusy)
		else $error("wordStrobe while serBusy is high");

	txIdleHigh: assert property (@(posedge sys_clk_p) disable iff (!rstN)
		!txBusy |-> uartTx)   // idle line rests at stop level
		else $error("uartTx low while transmitter idle");

endmodule

bind uartMemHarness uartMemHarness_props u_harnessProps (
	.sys_clk_p (sys_clk_p),
	.rstN      (rstN),
	.cmdStrobe (cmdStrobe),
	.wordStrobe(wordStrobe),
	.serBusy   (serBusy),
	.txBusy    (txBusy),
	.uartTx    (uartTx)
);

// File: dv/tbUartMemHarness.sv
`timescale 1ns/100ps

module tbUartMemHarness;

	parameter int clkPerBit = 16;
	localparam int replyWait  = 200 * clkPerBit;   // 20 frames of 10 bits
	localparam int maxRecords = 64;

	logic        sys_clk_p;
	logic        rstN;
	logic        uartRx;
	wire         uartTx;
	logic [59:0] patterns [maxRecords];   // tag nibble, then 56 bits
	logic [7:0]  expBytes [$];
	int          mismatchCnt;
	int          missingCnt;
	int          extraCnt;

	uartMemHarness #(
		.clkPerBit(clkPerBit),
		.addrWidth(8)
	) u_uartMemHarness (
		.sys_clk_p(sys_clk_p),
		.rstN     (rstN),
		.uartRx   (uartRx),
		.uartTx   (uartTx)
	);

	initial begin
		sys_clk_p = 1'b0;
		forever #10 sys_clk_p = ~sys_clk_p;
	end

	//------------------------------------------------------------
	// serial host model
	//------------------------------------------------------------
	task automatic sendFrame(input logic [55:0] frame);
		logic [9:0] bits;
		int b;
		int i;
		for (b = 6; b >= 0; b--) begin
			bits = {1'b1, frame[b*8 +: 8], 1'b0};   // stop, data, start
			for (i = 0; i < 10; i++) begin
				uartRx <= bits[i];
				repeat (clkPerBit) @(posedge sys_clk_p);
			end
		end
	endtask

	task automatic receiveByte(output logic [7:0] value, output bit arrived);
		int waitCnt;
		int i;
		value   = '0;
		arrived = 1'b0;
		waitCnt = 0;
		while (uartTx !== 1'b0 && waitCnt < replyWait) begin
			@(posedge sys_clk_p);
			waitCnt++;
		end
		if (uartTx === 1'b0) begin
			repeat (clkPerBit / 2) @(posedge sys_clk_p);   // mid start bit
			for (i = 0; i < 8; i++) begin
				repeat (clkPerBit) @(posedge sys_clk_p);
				value[i] = uartTx;   // lsb first
			end
			repeat (clkPerBit) @(posedge sys_clk_p);   // mid stop bit
			assert (uartTx === 1'b1) else begin
				$display("CHECK FAILED at %0t: stop bit of reply byte %h is low",
					$time, value);
				mismatchCnt++;
			end
			arrived = 1'b1;
		end
	endtask

	// expected bytes sit in expBytes, one extra listen catches spurious bytes
	task automatic collectReply(input logic [55:0] frame);
		logic [7:0] value;
		bit         arrived;
		int         n;
		arrived = 1'b1;
		n = 0;
		while (arrived && n < expBytes.size()) begin
			receiveByte(value, arrived);
			assert (arrived) else begin
				$display("no reply byte %0d within 20 frames after command %h", n, frame);
				missingCnt++;
			end
			assert (!arrived || value === expBytes[n]) else begin
				$display("CHECK FAILED at %0t: command %h byte %0d is %h, expected %h",
					$time, frame, n, value, expBytes[n]);
				mismatchCnt++;
			end
			n++;
		end
		if (arrived) begin
			receiveByte(value, arrived);
			assert (!arrived) else begin
				$display("unexpected reply byte %h after command %h", value, frame);
				extraCnt++;
			end
		end
	endtask

	//------------------------------------------------------------
	// pattern playback
	//------------------------------------------------------------
	initial begin
		logic [59:0] rec;
		int idx;
		int k;
		uartRx      = 1'b1;   // idle line
		rstN        = 1'b0;
		mismatchCnt = 0;
		missingCnt  = 0;
		extraCnt    = 0;
		idx         = 0;
		$readmemh("dv/harnessPatterns.hex", patterns);
		repeat (4) @(posedge sys_clk_p);
		rstN <= 1'b1;
		repeat (4) @(posedge sys_clk_p);
		while (idx < maxRecords && patterns[idx][59:56] === 4'hC) begin
			rec = patterns[idx];
			idx++;
			expBytes.delete();
			while (idx < maxRecords && patterns[idx][59:56] === 4'hE) begin
				// byte count in [55:48], bytes right aligned
				for (k = int'(patterns[idx][55:48]) - 1; k >= 0; k--)
					expBytes.push_back(patterns[idx][k*8 +: 8]);
				idx++;
			end
			fork
				sendFrame(rec[55:0]);
				collectReply(rec[55:0]);
			join
		end
		$display("errors: %0d mismatched, %0d missing, %0d unexpected",
			mismatchCnt, missingCnt, extraCnt);
		if (mismatchCnt + missingCnt + extraCnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: dv/harnessPatterns.hex
// C record: tag C, opcode, address, payload of one command frame
// E record: tag E, reply byte count, unused, reply bytes msb first
C_00_0011_11223344
C_00_0012_A5A55A5A
C_00_0014_DEADBEEF
C_02_0011_00010001
E_04_0000_11223344
C_02_0012_00010001
E_04_0000_A5A55A5A
C_02_0014_00010001
E_04_0000_DEADBEEF
C_00_0010_0A0B0C0D
C_00_0013_1A1B1C1D
C_00_0016_2A2B2C2D
C_02_0010_00030003
E_04_0000_0A0B0C0D
E_04_0000_1A1B1C1D
E_04_0000_2A2B2C2D
C_00_01FF_CAFEF00D
C_02_00FF_00020012
E_04_0000_CAFEF00D
E_04_0000_11223344
C_FF_0011_00000000
E_01_0000_000000EE
C_02_0011_00010001
E_04_0000_11223344
C_02_0010_00000001
C_00_0015_55667788
C_00_0017_99AABBCC
C_02_0010_00080001
E_04_0000_0A0B0C0D
E_04_0000_11223344
E_04_0000_A5A55A5A
E_04_0000_1A1B1C1D
E_04_0000_DEADBEEF
E_04_0000_55667788
E_04_0000_2A2B2C2D
E_04_0000_99AABBCC

// File: flist.f
src/harnessPkg.sv
src/uartLink.sv
src/cmdDecode.sv
src/memExecute.sv
src/resultSerialize.sv
src/uartMemHarness.sv
dv/uartMemHarness_props.sv
dv/tbUartMemHarness.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbUartMemHarness
CLKPERBIT ?= 16

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -GclkPerBit=$(CLKPERBIT)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
